// ==== verilog.f ====
+incdir+tb
design/procPkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/resultStage.sv
design/procCore.sv
tb/procCoreTb.sv

// ==== Bender.yml ====
package:
  name: proc_core

sources:
  - files:
      - design/procPkg.sv
      - design/fetchStage.sv
      - design/decodeStage.sv
      - design/executeStage.sv
      - design/resultStage.sv
      - design/procCore.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/procCoreTb.sv

// ==== tb/procPrograms.svh ====
// Program table, filled in program order by buildTable
// pushInstr columns are instruction word, expected trace register (NoRow if none), value

localparam int MaxProgs = 8;
localparam int MaxWords = 16;
localparam int MaxRows  = 16;
localparam int NoRow    = -1;

localparam logic [15:0] HaltWord    = {procPkg::OpHalt, 11'd0};
localparam logic [15:0] NopWord     = {procPkg::OpNop, 11'd0};
// Opcode 5'b00010 is unassigned
localparam logic [15:0] IllegalWord = 16'h1000;

typedef struct packed {
   logic [2:0]  rdIdx;
   logic [15:0] data;
} rowT;

logic [15:0] progWords [MaxProgs][MaxWords];
rowT         progRows  [MaxProgs][MaxRows];
int          progLen   [MaxProgs];
int          rowCount  [MaxProgs];
logic        progErr   [MaxProgs];
int          progCount;

function automatic logic [15:0] regForm(input procPkg::opcodeE op, input int rs, input int rt,
                                        input int rd, input int fn);
   return {op, rs[2:0], rt[2:0], rd[2:0], fn[1:0]};
endfunction

// For a store the rd field carries the data register
function automatic logic [15:0] immForm(input procPkg::opcodeE op, input int rs, input int rd,
                                        input int imm);
   return {op, rs[2:0], rd[2:0], imm[4:0]};
endfunction

function automatic logic [15:0] byteForm(input procPkg::opcodeE op, input int rs, input int imm);
   return {op, rs[2:0], imm[7:0]};
endfunction

function automatic logic [15:0] jumpForm(input procPkg::opcodeE op, input int disp);
   return {op, disp[10:0]};
endfunction

task automatic startProgram(input logic expErr);
   progErr[progCount]  = expErr;
   progLen[progCount]  = 0;
   rowCount[progCount] = 0;
   progCount++;
endtask

task automatic pushInstr(input logic [15:0] instrWord, input int rd, input int value);
   int p;
   p = progCount - 1;
   progWords[p][progLen[p]] = instrWord;
   progLen[p]++;
   if (rd != NoRow) begin
      progRows[p][rowCount[p]] = {rd[2:0], value[15:0]};
      rowCount[p]++;
   end
endtask

task automatic buildTable();
   progCount = 0;

   // ALU register and immediate operations, r1 = 0x0025 and r2 = -13
   startProgram(1'b0);
   pushInstr(byteForm(procPkg::OpLbi, 1, 8'h25), 1, 16'h0025);
   pushInstr(byteForm(procPkg::OpLbi, 2, 8'hF3), 2, 16'hFFF3);
   pushInstr(regForm(procPkg::OpAlu, 1, 2, 3, 0), 3, 16'h0018);
   pushInstr(regForm(procPkg::OpAlu, 1, 2, 4, 1), 4, 16'h0032);
   pushInstr(regForm(procPkg::OpAlu, 1, 2, 5, 2), 5, 16'hFFD6);
   pushInstr(regForm(procPkg::OpAlu, 1, 2, 6, 3), 6, 16'h0004);
   pushInstr(regForm(procPkg::OpSlt, 2, 1, 7, 0), 7, 16'h0001);
   pushInstr(regForm(procPkg::OpSeq, 1, 1, 0, 0), 0, 16'h0001);
   pushInstr(regForm(procPkg::OpSlt, 1, 2, 7, 0), 7, 16'h0000);
   pushInstr(immForm(procPkg::OpAddi, 1, 3, -3), 3, 16'h0022);
   pushInstr(immForm(procPkg::OpSubi, 2, 4, 5), 4, 16'hFFEE);
   pushInstr(immForm(procPkg::OpXori, 1, 5, 15), 5, 16'h002A);
   pushInstr(immForm(procPkg::OpAndni, 1, 6, 7), 6, 16'h0020);
   pushInstr(HaltWord, NoRow, 0);

   // Forwarding from the result register and from writeback
   startProgram(1'b0);
   pushInstr(byteForm(procPkg::OpLbi, 1, 8'h07), 1, 16'h0007);
   pushInstr(immForm(procPkg::OpAddi, 1, 2, 1), 2, 16'h0008);
   pushInstr(regForm(procPkg::OpAlu, 2, 1, 3, 0), 3, 16'h000F);
   pushInstr(NopWord, NoRow, 0);
   pushInstr(regForm(procPkg::OpAlu, 3, 1, 4, 1), 4, 16'h0008);
   pushInstr(regForm(procPkg::OpAlu, 4, 3, 4, 2), 4, 16'h0007);
   // Both older copies of r4 are in flight, the younger one must win
   pushInstr(regForm(procPkg::OpAlu, 3, 4, 5, 3), 5, 16'h0008);
   pushInstr(HaltWord, NoRow, 0);

   // Store then load, with a load-use stall on the add
   startProgram(1'b0);
   pushInstr(byteForm(procPkg::OpLbi, 1, 8'h10), 1, 16'h0010);
   pushInstr(byteForm(procPkg::OpLbi, 2, 8'h5A), 2, 16'h005A);
   pushInstr(immForm(procPkg::OpSt, 1, 2, 4), NoRow, 0);
   pushInstr(immForm(procPkg::OpLd, 1, 3, 4), 3, 16'h005A);
   pushInstr(regForm(procPkg::OpAlu, 3, 2, 4, 0), 4, 16'h00B4);
   pushInstr(immForm(procPkg::OpSt, 1, 4, -2), NoRow, 0);
   pushInstr(immForm(procPkg::OpLd, 1, 5, -2), 5, 16'h00B4);
   pushInstr(immForm(procPkg::OpLd, 1, 6, 4), 6, 16'h005A);
   pushInstr(HaltWord, NoRow, 0);

   // Branches and jump, the skipped words write r2, r3 and stale r6, r7
   startProgram(1'b0);
   pushInstr(byteForm(procPkg::OpLbi, 1, 8'h00), 1, 16'h0000);
   pushInstr(byteForm(procPkg::OpBeqz, 1, 2), NoRow, 0);
   pushInstr(byteForm(procPkg::OpLbi, 2, 8'h11), NoRow, 0);
   pushInstr(byteForm(procPkg::OpLbi, 3, 8'h22), NoRow, 0);
   pushInstr(byteForm(procPkg::OpLbi, 4, 8'h33), 4, 16'h0033);
   pushInstr(byteForm(procPkg::OpBnez, 1, 3), NoRow, 0);
   pushInstr(byteForm(procPkg::OpLbi, 5, 8'h44), 5, 16'h0044);
   pushInstr(jumpForm(procPkg::OpJ, 2), NoRow, 0);
   pushInstr(byteForm(procPkg::OpLbi, 6, 8'h55), NoRow, 0);
   pushInstr(byteForm(procPkg::OpLbi, 7, 8'h66), NoRow, 0);
   pushInstr(byteForm(procPkg::OpLbi, 6, 8'h77), 6, 16'h0077);
   pushInstr(byteForm(procPkg::OpBnez, 6, 1), NoRow, 0);
   pushInstr(byteForm(procPkg::OpLbi, 7, 8'h12), NoRow, 0);
   pushInstr(byteForm(procPkg::OpBeqz, 5, 1), NoRow, 0);
   pushInstr(byteForm(procPkg::OpLbi, 7, 8'h7F), 7, 16'h007F);
   pushInstr(HaltWord, NoRow, 0);

   // Words behind the halt never retire
   startProgram(1'b0);
   pushInstr(byteForm(procPkg::OpLbi, 3, 8'h40), 3, 16'h0040);
   pushInstr(HaltWord, NoRow, 0);
   pushInstr(byteForm(procPkg::OpLbi, 4, 8'h11), NoRow, 0);
   pushInstr(byteForm(procPkg::OpLbi, 5, 8'h22), NoRow, 0);

   // Illegal opcode raises err
   startProgram(1'b1);
   pushInstr(byteForm(procPkg::OpLbi, 1, 8'h03), 1, 16'h0003);
   pushInstr(immForm(procPkg::OpAddi, 1, 2, 2), 2, 16'h0005);
   pushInstr(IllegalWord, NoRow, 0);
   pushInstr(HaltWord, NoRow, 0);
endtask

// ==== tb/procCoreTb.sv ====
`timescale 1ns/10ps

module procCoreTb;

   // Halts written behind each program so fetch never reads stale words
   localparam int PadWords = 4;

   logic          clk;
   logic          arstN;
   logic          run;
   logic          imemWe;
   procPkg::wordT imemAddr;
   procPkg::wordT imemData;
   procPkg::wbT   trace;
   logic          halted;
   logic          err;
   int            cycleLimit;
   int            runCycles;

   `include "procPrograms.svh"

   procCore #(
      .ImemDepth(256),
      .DmemDepth(256)
   ) u_procCore (
      .clk      (clk),
      .arstN    (arstN),
      .run      (run),
      .imemWe   (imemWe),
      .imemAddr (imemAddr),
      .imemData (imemData),
      .trace    (trace),
      .halted   (halted),
      .err      (err)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

   task automatic expectEqual(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("[ERROR] %0t: %s (got 0x%0h, expected 0x%0h)", $time, what, actual, expected);
         $display("sim failed");
         $fatal(1);
      end
   endtask

   task automatic runProgram(input int p);
      int rowPtr;
      int illegalSeen;
      @(negedge clk);
      run   = 1'b0;
      arstN = 1'b0;
      repeat (2) @(negedge clk);
      arstN = 1'b1;

      // One word per cycle through the load port while the core is held
      for (int i = 0; i < progLen[p] + PadWords; i++) begin
         imemWe   = 1'b1;
         imemAddr = 16'(i);
         if (i < progLen[p]) begin
            imemData = progWords[p][i];
         end else begin
            imemData = HaltWord;
         end
         @(negedge clk);
      end
      imemWe = 1'b0;
      run    = 1'b1;

      // Only the order of trace rows is compared
      rowPtr      = 0;
      illegalSeen = 0;
      while (halted !== 1'b1) begin
         @(negedge clk);
         if (trace.illegal === 1'b1) begin
            illegalSeen++;
         end
         if (trace.valid === 1'b1) begin
            expectEqual(rowPtr < rowCount[p], 1,
                        $sformatf("program %0d retired more rows than expected", p));
            expectEqual(trace.rdIdx, progRows[p][rowPtr].rdIdx,
                        $sformatf("program %0d row %0d register", p, rowPtr));
            expectEqual(trace.data, progRows[p][rowPtr].data,
                        $sformatf("program %0d row %0d data", p, rowPtr));
            rowPtr++;
         end
      end
      expectEqual(rowPtr, rowCount[p], $sformatf("program %0d rows seen at halt", p));
      expectEqual(err, progErr[p], $sformatf("program %0d err level", p));
      expectEqual(trace.isHalt, 1'b1, $sformatf("program %0d halt record at writeback", p));
      expectEqual(illegalSeen, int'(progErr[p]),
                  $sformatf("program %0d illegal records at writeback", p));

      // Frozen after halt
      repeat (2) begin
         @(negedge clk);
         expectEqual(trace.valid, 0, $sformatf("program %0d row after halt", p));
         expectEqual(halted, 1, $sformatf("program %0d halted dropped", p));
      end
   endtask

   // Counts only running cycles
   initial begin
      runCycles = 0;
      while (runCycles <= cycleLimit) begin
         @(posedge clk);
         if (run) begin
            runCycles++;
         end
      end
      $display("Timeout: the core did not halt within %0d running cycles", cycleLimit);
      $display("sim failed");
      $fatal(1);
   end

   initial begin
      arstN    = 1'b0;
      run      = 1'b0;
      imemWe   = 1'b0;
      imemAddr = '0;
      imemData = '0;
      buildTable();
      cycleLimit = 0;
      for (int p = 0; p < progCount; p++) begin
         cycleLimit += 3 * progLen[p] + 10;
      end
      for (int p = 0; p < progCount; p++) begin
         runProgram(p);
      end
      $display("sim passed");
      $finish;
   end

endmodule

// ==== design/procCore.sv ====
`timescale 1ns/10ps

module procCore #(
   parameter int ImemDepth = 256,
   parameter int DmemDepth = 256
) (
   input  logic          clk,
   input  logic          arstN,
   input  logic          run,
   input  logic          imemWe,
   input  procPkg::wordT imemAddr,
   input  procPkg::wordT imemData,
   output procPkg::wbT   trace,
   output logic          halted,
   output logic          err
);

   logic           stageRun;
   procPkg::instrU instr;
   procPkg::wordT  pcPlusTwo;
   logic           instrValid;
   logic           stall;
   logic           redirect;
   procPkg::wordT  newPc;
   procPkg::decExT decEx;
   procPkg::exResT exRes;
   procPkg::wbT    wbRec;

   // Every stage freezes once halt reaches writeback
   assign stageRun = run && !halted;
   assign trace    = wbRec;

   fetchStage #(
      .ImemDepth(ImemDepth)
   ) u_fetchStage (
      .clk        (clk),
      .arstN      (arstN),
      .run        (stageRun),
      .imemWe     (imemWe),
      .imemAddr   (imemAddr),
      .imemData   (imemData),
      .stall      (stall),
      .redirect   (redirect),
      .newPc      (newPc),
      .instr      (instr),
      .pcPlusTwo  (pcPlusTwo),
      .instrValid (instrValid)
   );

   decodeStage u_decodeStage (
      .clk        (clk),
      .arstN      (arstN),
      .run        (stageRun),
      .instr      (instr),
      .pcPlusTwo  (pcPlusTwo),
      .instrValid (instrValid),
      .exRes      (exRes),
      .wb         (wbRec),
      .decEx      (decEx),
      .stall      (stall),
      .redirect   (redirect),
      .newPc      (newPc)
   );

   executeStage u_executeStage (
      .clk   (clk),
      .arstN (arstN),
      .run   (stageRun),
      .decEx (decEx),
      .wb    (wbRec),
      .exRes (exRes)
   );

   resultStage #(
      .DmemDepth(DmemDepth)
   ) u_resultStage (
      .clk    (clk),
      .arstN  (arstN),
      .run    (stageRun),
      .exRes  (exRes),
      .wb     (wbRec),
      .halted (halted),
      .err    (err)
   );

endmodule

// ==== design/resultStage.sv ====
`timescale 1ns/10ps

module resultStage #(
   parameter int DmemDepth = 256
) (
   input  logic           clk,
   input  logic           arstN,
   input  logic           run,
   input  procPkg::exResT exRes,
   output procPkg::wbT    wb,
   output logic           halted,
   output logic           err
);

   localparam int AddrW = $clog2(DmemDepth);

   procPkg::wordT    dmem [DmemDepth];
   logic [AddrW-1:0] wordIdx;
   procPkg::wordT    loadData;
   logic             errSeen;

   // Word index from the byte address
   assign wordIdx  = exRes.aluResult[AddrW:1];
   assign loadData = dmem[wordIdx];

   always_ff @(posedge clk) begin
      if (run && exRes.ctrl.memWrite) begin
         dmem[wordIdx] <= exRes.storeData;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         wb <= '0;
      end else if (run) begin
         wb.valid   <= exRes.ctrl.regWrite;
         wb.rdIdx   <= exRes.rdIdx;
         wb.data    <= exRes.ctrl.memToReg ? loadData : exRes.aluResult;
         wb.isHalt  <= exRes.ctrl.isHalt;
         wb.illegal <= exRes.ctrl.illegal;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         errSeen <= 1'b0;
      end else if (wb.illegal) begin
         errSeen <= 1'b1;
      end
   end

   // A halt record freezes the pipeline, so it stays in wb until reset
   assign halted = wb.isHalt;
   assign err    = errSeen || wb.illegal;

endmodule

// ==== design/executeStage.sv ====
`timescale 1ns/10ps

module executeStage (
   input  logic           clk,
   input  logic           arstN,
   input  logic           run,
   input  procPkg::decExT decEx,
   input  procPkg::wbT    wb,
   output procPkg::exResT exRes
);

   procPkg::wordT opA;
   procPkg::wordT fwdRt;
   procPkg::wordT opB;
   procPkg::wordT aluResult;

   // Younger result wins over the writeback record
   function automatic procPkg::wordT pickOperand(input procPkg::regIdxT idx,
                                                 input procPkg::wordT   regVal,
                                                 input procPkg::exResT  resReg,
                                                 input procPkg::wbT     wbRec);
      if (resReg.ctrl.regWrite && resReg.rdIdx == idx) begin
         return resReg.aluResult;
      end else if (wbRec.valid && wbRec.rdIdx == idx) begin
         return wbRec.data;
      end
      return regVal;
   endfunction

   always_comb begin
      opA   = pickOperand(decEx.rsIdx, decEx.rsVal, exRes, wb);
      fwdRt = pickOperand(decEx.rtIdx, decEx.rtVal, exRes, wb);
      opB   = decEx.ctrl.aluSrcImm ? decEx.imm : fwdRt;
      case (decEx.ctrl.aluOp)
         procPkg::AluAdd:   aluResult = opA + opB;
         procPkg::AluSub:   aluResult = opA - opB;
         procPkg::AluXor:   aluResult = opA ^ opB;
         procPkg::AluAndn:  aluResult = opA & ~opB;
         procPkg::AluSlt:   aluResult = ($signed(opA) < $signed(opB)) ? 16'd1 : 16'd0;
         procPkg::AluSeq:   aluResult = (opA == opB) ? 16'd1 : 16'd0;
         procPkg::AluPassB: aluResult = opB;
         default:           aluResult = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         exRes <= '0;
      end else if (run) begin
         exRes.ctrl      <= decEx.ctrl;
         exRes.rdIdx     <= decEx.rdIdx;
         exRes.aluResult <= aluResult;
         // Store data takes the forwarded rt as well
         exRes.storeData <= fwdRt;
      end
   end

endmodule

// ==== design/decodeStage.sv ====
`timescale 1ns/10ps

module decodeStage (
   input  logic           clk,
   input  logic           arstN,
   input  logic           run,
   input  procPkg::instrU instr,
   input  procPkg::wordT  pcPlusTwo,
   input  logic           instrValid,
   input  procPkg::exResT exRes,
   input  procPkg::wbT    wb,
   output procPkg::decExT decEx,
   output logic           stall,
   output logic           redirect,
   output procPkg::wordT  newPc
);

   procPkg::wordT   regFile [8];
   procPkg::ctrlT   ctrl;
   procPkg::regIdxT rsIdx;
   procPkg::regIdxT rtIdx;
   procPkg::regIdxT rdIdx;
   procPkg::wordT   rsVal;
   procPkg::wordT   rtVal;
   procPkg::wordT   imm;
   logic            readsRs;
   logic            readsRt;
   logic            isBranch;
   logic            isJump;
   logic            taken;
   logic            loadUse;
   logic            branchHazard;

   // Store data sits in bits 7:5 like the R-format rt
   assign rsIdx = instr.r.rs;
   assign rtIdx = instr.r.rt;

   always_comb begin
      ctrl       = '0;
      ctrl.valid = 1'b1;
      ctrl.aluOp = procPkg::AluAdd;
      rdIdx      = instr.i.rd;
      imm        = {{11{instr.i.imm[4]}}, instr.i.imm};
      readsRs    = 1'b0;
      readsRt    = 1'b0;
      isBranch   = 1'b0;
      isJump     = 1'b0;
      case (instr.r.opcode)
         procPkg::OpHalt: ctrl.isHalt = 1'b1;
         procPkg::OpNop: ;
         procPkg::OpAddi, procPkg::OpSubi, procPkg::OpXori, procPkg::OpAndni: begin
            ctrl.aluOp     = procPkg::aluOpE'({1'b0, instr.r.opcode[1:0]});
            ctrl.aluSrcImm = 1'b1;
            ctrl.regWrite  = 1'b1;
            readsRs        = 1'b1;
         end
         procPkg::OpLbi: begin
            // Destination is the rs field
            ctrl.aluOp     = procPkg::AluPassB;
            ctrl.aluSrcImm = 1'b1;
            ctrl.regWrite  = 1'b1;
            rdIdx          = instr.b.rs;
            imm            = {{8{instr.b.imm[7]}}, instr.b.imm};
         end
         procPkg::OpLd: begin
            ctrl.aluSrcImm = 1'b1;
            ctrl.regWrite  = 1'b1;
            ctrl.memRead   = 1'b1;
            ctrl.memToReg  = 1'b1;
            readsRs        = 1'b1;
         end
         procPkg::OpSt: begin
            ctrl.aluSrcImm = 1'b1;
            ctrl.memWrite  = 1'b1;
            readsRs        = 1'b1;
            readsRt        = 1'b1;
         end
         procPkg::OpAlu, procPkg::OpSeq, procPkg::OpSlt: begin
            if (instr.r.opcode == procPkg::OpSeq) begin
               ctrl.aluOp = procPkg::AluSeq;
            end else if (instr.r.opcode == procPkg::OpSlt) begin
               ctrl.aluOp = procPkg::AluSlt;
            end else begin
               ctrl.aluOp = procPkg::aluOpE'({1'b0, instr.r.func});
            end
            ctrl.regWrite = 1'b1;
            rdIdx         = instr.r.rd;
            readsRs       = 1'b1;
            readsRt       = 1'b1;
         end
         procPkg::OpBeqz, procPkg::OpBnez: begin
            isBranch = 1'b1;
            readsRs  = 1'b1;
            imm      = {{8{instr.b.imm[7]}}, instr.b.imm};
         end
         procPkg::OpJ: begin
            isJump = 1'b1;
            imm    = {{5{instr.j.disp[10]}}, instr.j.disp};
         end
         default: ctrl.illegal = 1'b1;
      endcase
      if (!instrValid) begin
         ctrl = '0;
      end
   end

   // Write before read
   assign rsVal = (wb.valid && wb.rdIdx == rsIdx) ? wb.data : regFile[rsIdx];
   assign rtVal = (wb.valid && wb.rdIdx == rtIdx) ? wb.data : regFile[rtIdx];

   assign taken = isJump ||
                  (isBranch && ((rsVal == '0) == (instr.r.opcode == procPkg::OpBeqz)));
   assign newPc = pcPlusTwo + (imm << 1);

   // Load data is only ready once the load has left the result stage
   assign loadUse = decEx.ctrl.valid && decEx.ctrl.memRead &&
                    ((readsRs && decEx.rdIdx == rsIdx) || (readsRt && decEx.rdIdx == rtIdx));

   // Branch compares in decode, so wait until rs can come from the register file
   assign branchHazard = isBranch &&
                         ((decEx.ctrl.regWrite && decEx.rdIdx == rsIdx) ||
                          (exRes.ctrl.regWrite && exRes.rdIdx == rsIdx));

   assign stall    = instrValid && (loadUse || branchHazard);
   assign redirect = instrValid && !stall && taken;

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 8; i++) begin
            regFile[i] <= '0;
         end
      end else if (wb.valid) begin
         regFile[wb.rdIdx] <= wb.data;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         decEx <= '0;
      end else if (run) begin
         if (stall) begin
            decEx.ctrl <= '0;
         end else begin
            decEx.ctrl <= ctrl;
         end
         decEx.rsIdx <= rsIdx;
         decEx.rtIdx <= rtIdx;
         decEx.rdIdx <= rdIdx;
         decEx.rsVal <= rsVal;
         decEx.rtVal <= rtVal;
         decEx.imm   <= imm;
      end
   end

endmodule

// ==== design/fetchStage.sv ====
`timescale 1ns/10ps

module fetchStage #(
   parameter int ImemDepth = 256
) (
   input  logic           clk,
   input  logic           arstN,
   input  logic           run,
   input  logic           imemWe,
   input  procPkg::wordT  imemAddr,
   input  procPkg::wordT  imemData,
   input  logic           stall,
   input  logic           redirect,
   input  procPkg::wordT  newPc,
   output procPkg::instrU instr,
   output procPkg::wordT  pcPlusTwo,
   output logic           instrValid
);

   localparam int AddrW = $clog2(ImemDepth);

   procPkg::wordT imem [ImemDepth];
   procPkg::wordT pc;
   procPkg::wordT pcNext;
   procPkg::wordT fetchWord;

   // PC is a byte address, the array holds words
   assign pcNext    = pc + 16'd2;
   assign fetchWord = imem[pc[AddrW:1]];

   // Load port, only while the core is held
   always_ff @(posedge clk) begin
      if (imemWe && !run) begin
         imem[imemAddr[AddrW-1:0]] <= imemData;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc         <= '0;
         instrValid <= 1'b0;
      end else if (run) begin
         if (redirect) begin
            // Drop the word fetched behind the branch
            pc         <= newPc;
            instrValid <= 1'b0;
         end else if (!stall) begin
            pc         <= pcNext;
            instrValid <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (run && !redirect && !stall) begin
         instr     <= fetchWord;
         pcPlusTwo <= pcNext;
      end
   end

endmodule

// ==== design/procPkg.sv ====
package procPkg;

   typedef logic [15:0] wordT;
   typedef logic [2:0]  regIdxT;

   // Opcodes of the kept subset, the rest decode as illegal
   typedef enum logic [4:0] {
      OpHalt  = 5'b00000,
      OpNop   = 5'b00001,
      OpJ     = 5'b00100,
      OpAddi  = 5'b01000,
      OpSubi  = 5'b01001,
      OpXori  = 5'b01010,
      OpAndni = 5'b01011,
      OpBeqz  = 5'b01100,
      OpBnez  = 5'b01101,
      OpSt    = 5'b10000,
      OpLd    = 5'b10001,
      OpLbi   = 5'b11000,
      OpAlu   = 5'b11011,
      OpSeq   = 5'b11100,
      OpSlt   = 5'b11101
   } opcodeE;

   // Low two bits match the immediate opcodes and the R-format function field
   typedef enum logic [2:0] {
      AluAdd   = 3'd0,
      AluSub   = 3'd1,
      AluXor   = 3'd2,
      AluAndn  = 3'd3,
      AluSlt   = 3'd4,
      AluSeq   = 3'd5,
      AluPassB = 3'd6
   } aluOpE;

   typedef struct packed {
      opcodeE     opcode;
      regIdxT     rs;
      regIdxT     rt;
      regIdxT     rd;
      logic [1:0] func;
   } rFormatT;

   typedef struct packed {
      opcodeE     opcode;
      regIdxT     rs;
      regIdxT     rd;
      logic [4:0] imm;
   } iFormatT;

   typedef struct packed {
      opcodeE     opcode;
      regIdxT     rs;
      logic [7:0] imm;
   } byteFormatT;

   typedef struct packed {
      opcodeE      opcode;
      logic [10:0] disp;
   } jFormatT;

   typedef union packed {
      rFormatT    r;
      iFormatT    i;
      byteFormatT b;
      jFormatT    j;
   } instrU;

   typedef struct packed {
      aluOpE aluOp;
      logic  aluSrcImm;
      logic  regWrite;
      logic  memRead;
      logic  memWrite;
      logic  memToReg;
      logic  isHalt;
      logic  illegal;
      logic  valid;
   } ctrlT;

   typedef struct packed {
      ctrlT   ctrl;
      regIdxT rsIdx;
      regIdxT rtIdx;
      regIdxT rdIdx;
      wordT   rsVal;
      wordT   rtVal;
      wordT   imm;
   } decExT;

   typedef struct packed {
      ctrlT   ctrl;
      regIdxT rdIdx;
      wordT   aluResult;
      wordT   storeData;
   } exResT;

   // Valid marks a register write, one cycle per retired instruction
   typedef struct packed {
      logic   valid;
      regIdxT rdIdx;
      wordT   data;
      logic   isHalt;
      logic   illegal;
   } wbT;

endpackage
